// ==== design/na_pkg.sv ====
// ##################
// network adapter types: config, bus, flit, region enum
// lfsr step function shared by seed logic and model
// ##################
`default_nettype none

package na_pkg;

   // static tile configuration, set once at the top
   typedef struct packed {
      logic [15:0]       num_tiles;       // tiles in the system
      logic              mp_simple;       // message passing present
      logic [7:0]        cores_per_tile;
      logic [31:0]       gmem_size;       // global memory size in bytes
      logic [15:0]       gmem_tile;       // tile holding global memory
      logic [31:0]       lmem_size;       // local memory size in bytes
      logic [6:0]        num_cts;         // compute tiles, up to 64
      logic [63:0][15:0] ct_list;         // entry i at ct_list[i]
   } na_config_t;

   // bus request, valid while cyc is high
   typedef struct packed {
      logic        cyc;
      logic        we;
      logic [15:0] adr;   // byte address
      logic [31:0] wdata;
   } bus_req_t;

   // bus response, same cycle as the request
   typedef struct packed {
      logic        ack;
      logic        err;
      logic [31:0] rdata;
   } bus_rsp_t;

   // flit kind, last one closes the packet
   typedef enum logic {
      flit_body = 1'b0,
      flit_last = 1'b1
   } flit_kind_e;

   typedef struct packed {
      flit_kind_e  kind;
      logic [31:0] data;
   } noc_flit_t;

   // address regions seen by the decoder
   typedef enum logic [1:0] {
      region_conf = 2'd0,  // 0x0000..0x0fff
      region_mp   = 2'd1,  // 0x1000..0x1fff
      region_none = 2'd2   // everything else
   } region_e;

   // fibonacci lfsr, taps 32 22 2 1, one bit per call
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};  // shift toward msb, feedback in at bit 0
   endfunction

endpackage

`default_nettype wire

// ==== design/na_bus_decode.sv ====
// ##################
// address region decoder and response merge
// ##################
`timescale 1ns/1ps
`default_nettype none

module na_bus_decode (
   input  wire na_pkg::bus_req_t  bus_req,   // from the bus master
   output na_pkg::bus_rsp_t       bus_rsp,
   output na_pkg::bus_req_t       conf_req,  // to config registers
   input  wire na_pkg::bus_rsp_t  conf_rsp,
   output na_pkg::bus_req_t       mp_req,    // to message transmitter
   input  wire na_pkg::bus_rsp_t  mp_rsp
);

   na_pkg::region_e region;

   // top nibble picks the region
   always_comb begin
      case (bus_req.adr[15:12])
         4'h0:    region = na_pkg::region_conf;
         4'h1:    region = na_pkg::region_mp;
         default: region = na_pkg::region_none;
      endcase
   end

   // request fans out, cyc only toward the selected target
   always_comb begin
      conf_req     = bus_req;
      conf_req.cyc = bus_req.cyc & (region == na_pkg::region_conf);
      mp_req       = bus_req;
      mp_req.cyc   = bus_req.cyc & (region == na_pkg::region_mp);
   end

   // response merge
   always_comb begin
      case (region)
         na_pkg::region_conf: begin
            bus_rsp = conf_rsp;
         end
         na_pkg::region_mp: begin
            bus_rsp = mp_rsp;
         end
         default: begin
            // nobody home
            bus_rsp.ack   = 1'b0;
            bus_rsp.err   = bus_req.cyc;  // idle stays quiet
            bus_rsp.rdata = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== design/na_conf.sv ====
// ##################
// config register file, compute tile list, seed lfsr
// ##################
`timescale 1ns/1ps
`default_nettype none

module na_conf #(
   parameter na_pkg::na_config_t CONFIG    = '0,
   parameter logic [15:0]        TILE_ID   = 16'd0,
   parameter logic [31:0]        CORE_BASE = 32'd0,
   parameter logic [31:0]        SEED_INIT = 32'd25812
) (
   input  wire                   clk,
   input  wire                   rst,
   input  wire na_pkg::bus_req_t req,
   output na_pkg::bus_rsp_t      rsp
);

   // word index, i.e. byte address bits 11:2
   typedef enum logic [9:0] {
      reg_tile_id   = 10'h000,
      reg_num_tiles = 10'h001,
      reg_conf      = 10'h003,  // feature bits
      reg_core_base = 10'h004,
      reg_cores     = 10'h006,  // cores per tile
      reg_gmem_size = 10'h007,
      reg_gmem_tile = 10'h008,
      reg_lmem_size = 10'h009,
      reg_num_cts   = 10'h00a,
      reg_seed      = 10'h00b
   } conf_reg_e;

   localparam int BIT_MP_SIMPLE = 0;
   localparam int BIT_DMA       = 1;  // no dma engine here

   logic [31:0] seed;
   logic        seed_rd;
   logic        in_ctlist;  // 0x200..0x27f, 32 words
   logic [4:0]  ct_word;    // list word n
   logic [31:0] ct_data;
   logic [31:0] rdata;

   assign in_ctlist = (req.adr[11:9] == 3'b001) && (req.adr[8:7] == 2'b00);
   assign ct_word   = req.adr[6:2];

   // word n holds entry 2n high, entry 2n+1 low
   assign ct_data = {CONFIG.ct_list[{ct_word, 1'b0}], CONFIG.ct_list[{ct_word, 1'b1}]};

   // read mux
   always_comb begin
      rdata = '0;  // holes read as zero
      if (in_ctlist) begin
         rdata = ct_data;
      end else begin
         case (req.adr[11:2])
            reg_tile_id:   rdata = {16'h0, TILE_ID};
            reg_num_tiles: rdata = {16'h0, CONFIG.num_tiles};
            reg_conf: begin
               rdata[BIT_MP_SIMPLE] = CONFIG.mp_simple;
               rdata[BIT_DMA]       = 1'b0;
            end
            reg_core_base: rdata = CORE_BASE;
            reg_cores:     rdata = {24'h0, CONFIG.cores_per_tile};
            reg_gmem_size: rdata = CONFIG.gmem_size;
            reg_gmem_tile: rdata = {16'h0, CONFIG.gmem_tile};
            reg_lmem_size: rdata = CONFIG.lmem_size;
            reg_num_cts:   rdata = {25'h0, CONFIG.num_cts};
            reg_seed:      rdata = seed;  // value before this read's step
            default:       rdata = '0;
         endcase
      end
   end

   // read only region, writes acked and dropped
   assign rsp.ack   = req.cyc;
   assign rsp.err   = 1'b0;
   assign rsp.rdata = rdata;

   // every acked seed read advances the lfsr
   assign seed_rd = req.cyc && !req.we && !in_ctlist && (req.adr[11:2] == reg_seed);

   always_ff @(posedge clk) begin
      if (rst) begin
         seed <= SEED_INIT;
      end else if (seed_rd) begin
         seed <= na_pkg::lfsr_step(seed);  // next reader gets a fresh word
      end
   end

endmodule

`default_nettype wire

// ==== design/na_mp_send.sv ====
// ##################
// message transmitter: flit queue, credits, noc output reg
// ##################
`timescale 1ns/1ps
`default_nettype none

module na_mp_send #(
   parameter int TX_DEPTH = 4,  // queue slots, power of two
   parameter int CREDITS  = 4   // downstream buffer slots
) (
   input  wire                   clk,
   input  wire                   rst,
   input  wire na_pkg::bus_req_t req,
   output na_pkg::bus_rsp_t      rsp,
   output logic                  flit_valid,
   output na_pkg::noc_flit_t     flit,
   input  wire                   credit_ret  // one pulse per credit
);

   localparam int AW = (TX_DEPTH > 1) ? $clog2(TX_DEPTH) : 1;
   localparam int CW = $clog2(CREDITS + 1);

   // word index within the mp region
   typedef enum logic [9:0] {
      mp_reg_body = 10'h000,  // w: body word, r: free slots
      mp_reg_last = 10'h001   // w: last word, r: credits
   } mp_reg_e;

   na_pkg::noc_flit_t queue [TX_DEPTH];
   logic [AW-1:0]     rd_ptr;
   logic [AW-1:0]     wr_ptr;
   logic [AW:0]       count;    // 0..TX_DEPTH
   logic [CW-1:0]     credits;

   logic              is_body;
   logic              is_last;
   logic              reg_hit;
   logic              full;
   logic              wr_ok;    // write accepted this cycle
   logic              send;     // flit leaves at this edge
   logic              bypass;   // queue empty, incoming word goes straight out
   logic              push;
   logic              pop;
   na_pkg::noc_flit_t in_flit;
   na_pkg::noc_flit_t next_flit;

   function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
      return (p == AW'(TX_DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   always_comb begin
      is_body = 1'b0;
      is_last = 1'b0;
      case (req.adr[11:2])
         mp_reg_body: is_body = 1'b1;
         mp_reg_last: is_last = 1'b1;
         default: ;
      endcase
   end

   assign reg_hit = is_body | is_last;
   assign full    = (count == (AW + 1)'(TX_DEPTH));
   assign wr_ok   = req.cyc & req.we & reg_hit & ~full;  // full queue drops the word

   assign in_flit.kind = is_last ? na_pkg::flit_last : na_pkg::flit_body;
   assign in_flit.data = req.wdata;

   // one flit per cycle while something waits and a credit is left
   assign send      = ((count != '0) | wr_ok) & (credits != '0);
   assign bypass    = (count == '0);
   assign next_flit = bypass ? in_flit : queue[rd_ptr];
   assign push      = wr_ok & ~(send & bypass);
   assign pop       = send & ~bypass;

   // bus side, answered in the same cycle
   always_comb begin
      rsp.ack   = req.cyc & reg_hit & (~req.we | ~full);
      rsp.err   = req.cyc & ~rsp.ack;  // full write or unmapped word
      rsp.rdata = '0;
      if (!req.we) begin
         if (is_body) begin
            rsp.rdata = 32'(TX_DEPTH) - 32'(count);  // free slots
         end else if (is_last) begin
            rsp.rdata = 32'(credits);
         end
      end
   end

   // control state
   always_ff @(posedge clk) begin
      if (rst) begin
         rd_ptr     <= '0;
         wr_ptr     <= '0;
         count      <= '0;
         credits    <= CW'(CREDITS);
         flit_valid <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         count      <= count + (AW + 1)'(push) - (AW + 1)'(pop);
         credits    <= credits + CW'(credit_ret) - CW'(send);  // both at once, no change
         flit_valid <= send;
      end
   end

   // payload storage
   always_ff @(posedge clk) begin
      if (push) begin
         queue[wr_ptr] <= in_flit;
      end
      if (send) begin
         flit <= next_flit;  // held until the next send
      end
   end

endmodule

`default_nettype wire

// ==== design/na_top.sv ====
// ##################
// network adapter top: decoder, config regs, transmitter
// ##################
`timescale 1ns/1ps
`default_nettype none

module na_top #(
   parameter na_pkg::na_config_t CONFIG    = '0,
   parameter logic [15:0]        TILE_ID   = 16'd0,
   parameter logic [31:0]        CORE_BASE = 32'd0,
   parameter logic [31:0]        SEED_INIT = 32'd25812,
   parameter int                 TX_DEPTH  = 4,
   parameter int                 CREDITS   = 4
) (
   input  wire                   clk,
   input  wire                   rst,
   input  wire na_pkg::bus_req_t bus_req,
   output na_pkg::bus_rsp_t      bus_rsp,
   output logic                  flit_valid,
   output na_pkg::noc_flit_t     flit,
   input  wire                   credit_ret
);

   na_pkg::bus_req_t conf_req;
   na_pkg::bus_rsp_t conf_rsp;
   na_pkg::bus_req_t mp_req;
   na_pkg::bus_rsp_t mp_rsp;

   na_bus_decode i_decode (
      .bus_req  (bus_req),
      .bus_rsp  (bus_rsp),
      .conf_req (conf_req),
      .conf_rsp (conf_rsp),
      .mp_req   (mp_req),
      .mp_rsp   (mp_rsp)
   );

   na_conf #(
      .CONFIG    (CONFIG),
      .TILE_ID   (TILE_ID),
      .CORE_BASE (CORE_BASE),
      .SEED_INIT (SEED_INIT)
   ) i_conf (
      .clk (clk),
      .rst (rst),
      .req (conf_req),
      .rsp (conf_rsp)
   );

   na_mp_send #(
      .TX_DEPTH (TX_DEPTH),
      .CREDITS  (CREDITS)
   ) i_mp_send (
      .clk        (clk),
      .rst        (rst),
      .req        (mp_req),
      .rsp        (mp_rsp),
      .flit_valid (flit_valid),
      .flit       (flit),
      .credit_ret (credit_ret)
   );

endmodule

`default_nettype wire

// ==== verification/na_tb.sv ====
// ####################
// network adapter testbench: clock, reset, directed tests
// compare tasks, payload lfsr, seed model, timeout
// ####################
`timescale 1ns/1ps
`default_nettype none

module na_tb;

   localparam logic [15:0] TILE_ID    = 16'h0007;
   localparam logic [31:0] CORE_BASE  = 32'd28;
   localparam logic [31:0] SEED_INIT  = 32'd25812;
   localparam int          TX_DEPTH   = 4;
   localparam int          CREDITS    = 4;
   localparam int          MAX_CYCLES = 2000;  // tests plus every flit wait, with room to spare
   localparam int          FLIT_WAIT  = 50;    // per wait for flits

   // 16 tiles, 5 compute tiles, message passing present
   localparam na_pkg::na_config_t CFG = '{
      num_tiles:      16'd16,
      mp_simple:      1'b1,
      cores_per_tile: 8'd4,
      gmem_size:      32'h0100_0000,
      gmem_tile:      16'd15,
      lmem_size:      32'h0001_0000,
      num_cts:        7'd5,
      ct_list:        {944'h0, 16'd13, 16'd11, 16'd6, 16'd3, 16'd1}  // entry 0 lowest
   };

   logic              clk;
   logic              rst;
   na_pkg::bus_req_t  bus_req;
   na_pkg::bus_rsp_t  bus_rsp;
   logic              flit_valid;
   na_pkg::noc_flit_t flit;
   logic              credit_ret;

   int                errors = 0;
   int                cycles = 0;
   logic [31:0]       rnd_state;    // payload lfsr
   logic [31:0]       seed_model;   // expected seed register
   na_pkg::noc_flit_t rx_q [$];     // flits seen on the link
   na_pkg::noc_flit_t exp_q [$];    // flits accepted by the queue, in order

   na_top #(
      .CONFIG    (CFG),
      .TILE_ID   (TILE_ID),
      .CORE_BASE (CORE_BASE),
      .SEED_INIT (SEED_INIT),
      .TX_DEPTH  (TX_DEPTH),
      .CREDITS   (CREDITS)
   ) i_dut (
      .clk        (clk),
      .rst        (rst),
      .bus_req    (bus_req),
      .bus_rsp    (bus_rsp),
      .flit_valid (flit_valid),
      .flit       (flit),
      .credit_ret (credit_ret)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // run limit
   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: run still going after %0d cycles", MAX_CYCLES);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   // link monitor, 1 ns before the falling edge, output register long settled
   always @(posedge clk) begin
      #4;
      if (!rst && flit_valid) begin
         rx_q.push_back(flit);
      end
   end

   // fibonacci, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // one lfsr step per payload bit
   function automatic logic [31:0] rand_word();
      logic [31:0] w;
      w = '0;
      for (int i = 0; i < 32; i++) begin
         rnd_state = lfsr_next(rnd_state);
         w = {w[30:0], rnd_state[0]};
      end
      return w;
   endfunction

   // register map of the config region
   function automatic logic [31:0] conf_value(input logic [15:0] adr);
      logic [31:0] v;
      int          n;
      v = '0;
      if (adr >= 16'h0200 && adr < 16'h0280) begin
         n = int'(adr - 16'h0200) / 4;  // list word
         v = {CFG.ct_list[2 * n], CFG.ct_list[2 * n + 1]};  // entry 2n in the high half
      end else begin
         case (adr)
            16'h0000: v = {16'h0, TILE_ID};
            16'h0004: v = {16'h0, CFG.num_tiles};
            16'h000c: v = {31'h0, CFG.mp_simple};  // dma bit stays 0
            16'h0010: v = CORE_BASE;
            16'h0018: v = {24'h0, CFG.cores_per_tile};
            16'h001c: v = CFG.gmem_size;
            16'h0020: v = {16'h0, CFG.gmem_tile};
            16'h0024: v = CFG.lmem_size;
            16'h0028: v = {25'h0, CFG.num_cts};
            default:  v = '0;  // holes
         endcase
      end
      return v;
   endfunction

   function automatic na_pkg::bus_rsp_t rsp_of(input logic a, input logic e,
                                                input logic [31:0] d);
      return '{ack: a, err: e, rdata: d};
   endfunction

   task automatic check_rsp(input na_pkg::bus_rsp_t got, input na_pkg::bus_rsp_t exp,
                            input bit with_data, input string what);
      if (got.ack !== exp.ack || got.err !== exp.err ||
          (with_data && got.rdata !== exp.rdata)) begin
         errors++;
         $display("Fail at %0t: %s, got ack %b err %b rdata %h, expected ack %b err %b rdata %h",
                  $time, what, got.ack, got.err, got.rdata, exp.ack, exp.err, exp.rdata);
      end
   endtask

   task automatic check_flit(input na_pkg::noc_flit_t got, input na_pkg::noc_flit_t exp,
                             input string what);
      if (got !== exp) begin
         errors++;
         $display("Fail at %0t: %s, got flit kind %b data %h, expected kind %b data %h",
                  $time, what, got.kind, got.data, exp.kind, exp.data);
      end
   endtask

   // one request over one rising edge, sampled just before it
   task automatic bus_cycle(input logic we, input logic [15:0] adr, input logic [31:0] wdata,
                            output na_pkg::bus_rsp_t rsp);
      @(negedge clk);
      bus_req    = '{cyc: 1'b1, we: we, adr: adr, wdata: wdata};
      credit_ret = 1'b0;
      #4;
      rsp = bus_rsp;
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(negedge clk);
         bus_req    = '{cyc: 1'b0, we: 1'b0, adr: 16'hffff, wdata: 32'h0};
         credit_ret = 1'b0;
      end
   endtask

   // idle bus must answer with neither ack nor err
   task automatic idle_check(input string what);
      idle(1);
      #4;
      check_rsp(bus_rsp, rsp_of(1'b0, 1'b0, 32'h0), 1'b1, what);
   endtask

   task automatic read_check(input logic [15:0] adr, input logic [31:0] exp,
                             input string what);
      na_pkg::bus_rsp_t r;
      bus_cycle(1'b0, adr, 32'h0, r);
      check_rsp(r, rsp_of(1'b1, 1'b0, exp), 1'b1, what);
   endtask

   // write of a random payload, queued as expected flit when accepted
   task automatic send_word(input logic [15:0] adr, input bit ok, input string what);
      na_pkg::bus_rsp_t  r;
      na_pkg::noc_flit_t f;
      f.data = rand_word();
      f.kind = (adr == 16'h1004) ? na_pkg::flit_last : na_pkg::flit_body;
      bus_cycle(1'b1, adr, f.data, r);
      check_rsp(r, rsp_of(ok, !ok, 32'h0), 1'b0, what);
      if (ok) begin
         exp_q.push_back(f);
      end
   endtask

   task automatic return_credits(input int n);
      repeat (n) begin
         @(negedge clk);
         bus_req.cyc = 1'b0;
         credit_ret  = 1'b1;  // one credit per cycle high
      end
      idle(1);
   endtask

   task automatic expect_flits(input int n, input string what);
      int waited;
      waited = 0;
      while (rx_q.size() < n && waited < FLIT_WAIT) begin
         idle(1);
         waited++;
      end
      if (rx_q.size() < n) begin
         errors++;
         $display("%s: only %0d of %0d flits arrived", what, rx_q.size(), n);
      end
      for (int i = 0; i < n && rx_q.size() > 0; i++) begin
         check_flit(rx_q.pop_front(), exp_q.pop_front(), what);
      end
   endtask

   // no flit may show up for n cycles
   task automatic quiet_link(input int n, input string what);
      idle(n);
      if (rx_q.size() != 0) begin
         errors++;
         $display("%s: %0d unexpected flits on the link", what, rx_q.size());
         rx_q.delete();
      end
   endtask

   task automatic test_conf_regs();
      logic [15:0] adrs [13];
      na_pkg::bus_rsp_t r;
      adrs = '{16'h0000, 16'h0004, 16'h000c, 16'h0010, 16'h0018, 16'h001c, 16'h0020,
               16'h0024, 16'h0028, 16'h0008, 16'h0014, 16'h0030, 16'h01fc};
      foreach (adrs[i]) begin
         read_check(adrs[i], conf_value(adrs[i]), $sformatf("config read %h", adrs[i]));
      end
      // read only, writes acked and dropped
      bus_cycle(1'b1, 16'h0000, 32'hdead_beef, r);
      check_rsp(r, rsp_of(1'b1, 1'b0, 32'h0), 1'b0, "config write 0000");
      bus_cycle(1'b1, 16'h001c, 32'h1234_5678, r);
      check_rsp(r, rsp_of(1'b1, 1'b0, 32'h0), 1'b0, "config write 001c");
      read_check(16'h0000, conf_value(16'h0000), "tile id after write");
      read_check(16'h001c, conf_value(16'h001c), "gmem size after write");
      idle(1);
   endtask

   task automatic test_ct_list();
      logic [15:0] adr;
      for (int n = 0; n < 4; n++) begin
         adr = 16'h0200 + 16'(4 * n);
         read_check(adr, conf_value(adr), $sformatf("compute tile word %0d", n));
      end
      read_check(16'h027c, conf_value(16'h027c), "last compute tile word");
      idle(1);
   endtask

   // back to back reads, each one steps the register
   task automatic test_seed();
      for (int i = 0; i < 3; i++) begin
         read_check(16'h002c, seed_model, $sformatf("seed read %0d", i));
         seed_model = lfsr_next(seed_model);
      end
      idle(1);
   endtask

   task automatic test_decode();
      na_pkg::bus_rsp_t r;
      bus_cycle(1'b0, 16'h2000, 32'h0, r);
      check_rsp(r, rsp_of(1'b0, 1'b1, 32'h0), 1'b1, "read 2000");
      bus_cycle(1'b1, 16'h8000, 32'h5555_aaaa, r);
      check_rsp(r, rsp_of(1'b0, 1'b1, 32'h0), 1'b1, "write 8000");
      bus_cycle(1'b0, 16'hf004, 32'h0, r);
      check_rsp(r, rsp_of(1'b0, 1'b1, 32'h0), 1'b1, "read f004");
      idle_check("idle cycle 1");
      idle_check("idle cycle 2");
   endtask

   task automatic test_send_credits();
      for (int i = 0; i < 6; i++) begin
         send_word((i == 5) ? 16'h1004 : 16'h1000, 1'b1, $sformatf("tx write %0d", i));
      end
      expect_flits(CREDITS, "credit limited send");
      quiet_link(4, "send without credits");
      read_check(16'h1004, 32'd0, "credits used up");
      read_check(16'h1000, 32'(TX_DEPTH - 6 + CREDITS), "free slots with words waiting");
      return_credits(6 - CREDITS);
      expect_flits(6 - CREDITS, "send after credit return");
      quiet_link(4, "drained queue");
   endtask

   task automatic test_overflow();
      for (int i = 0; i < TX_DEPTH; i++) begin
         send_word(16'h1000, 1'b1, $sformatf("fill write %0d", i));
      end
      read_check(16'h1000, 32'd0, "free slots with full queue");
      send_word(16'h1004, 1'b0, "write to full queue");  // dropped, no expected flit
      quiet_link(2, "full queue without credits");
      return_credits(TX_DEPTH);
      expect_flits(TX_DEPTH, "overflow drain");
      quiet_link(4, "after overflow drain");
      read_check(16'h1000, 32'(TX_DEPTH), "queue empty again");
      idle(1);
   endtask

   initial begin
      rst        = 1'b1;
      credit_ret = 1'b0;
      bus_req    = '{cyc: 1'b0, we: 1'b0, adr: 16'hffff, wdata: 32'h0};
      rnd_state  = 32'd25812;
      seed_model = SEED_INIT;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      test_seed();  // first, before anything reads the seed
      test_conf_regs();
      test_ct_list();
      test_decode();
      test_send_credits();
      test_overflow();
      idle(2);

      $display("run done after %0d cycles with %0d errors", cycles, errors);
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== na.f ====
design/na_pkg.sv
design/na_bus_decode.sv
design/na_conf.sv
design/na_mp_send.sv
design/na_top.sv
verification/na_tb.sv

// ==== Makefile ====
SIM     = verilator
TOP     = na_tb
FLIST   = na.f
FLAGS   = --binary --timing -Wno-fatal --top-module $(TOP)
OBJ_DIR = obj_dir
BIN     = $(OBJ_DIR)/V$(TOP)
PASS    = ALL CHECKS PASSED

SOURCES = $(shell cat $(FLIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FLIST)
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf $(OBJ_DIR)
